// ==== uart_pkg.sv ====
package uart_pkg;

	// ------------------------------
	// line timing
	// ------------------------------

	// clocks per uart bit, short so simulation stays fast
	localparam int clks_per_bit = 8;

	// ------------------------------
	// framing
	// ------------------------------

	// 0 none, 1 odd, 2 even
	localparam int parity_type = 2;

	// start, 8 data, parity if enabled, stop
	localparam int frame_bits = (parity_type == 0) ? 10 : 11;

	// one data byte on the line
	typedef logic [7:0] byte_t;

	// clock count inside one bit time
	typedef logic [$clog2(clks_per_bit)-1:0] bit_time_t;

	// bit position inside one frame
	typedef logic [$clog2(frame_bits)-1:0] bit_index_t;

endpackage

// ==== image_pkg.sv ====
package image_pkg;

	// ------------------------------
	// image geometry
	// ------------------------------

	// 12-bit rgb, r in [11:8], g in [7:4], b in [3:0]
	typedef logic [11:0] pixel_t;

	// 10 x 10 image
	localparam int image_size = 100;

	// frame memory address, wide enough for image_size
	typedef logic [6:0] addr_t;

	// ------------------------------
	// start button
	// ------------------------------

	// cycles a synchronized level must hold before it is taken
	localparam int debounce_cycles = 4;

	typedef logic [$clog2(debounce_cycles)-1:0] debounce_count_t;

	// streamer fsm
	typedef enum logic [1:0] {
		idle,
		fetch,
		wait_data,
		offer
	} stream_state_t;

endpackage

// ==== button_edge.sv ====
module button_edge
	import image_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic button,
	output logic press_pulse
);

	logic            sync_a;
	logic            sync_b;
	debounce_count_t stable_count;
	logic            stable_level;
	logic            stable_prev;

	// two flop synchronizer for the raw pin
	always_ff @(posedge clk) begin
		if (!reset) begin
			sync_a <= 1'b0;
			sync_b <= 1'b0;
		end else begin
			sync_a <= button;
			sync_b <= sync_a;
		end
	end

	// count cycles the synced level differs from the stable one
	always_ff @(posedge clk) begin
		if (!reset) begin
			stable_count <= '0;
			stable_level <= 1'b0;
		end else if (sync_b == stable_level) begin
			// bounce back, start over
			stable_count <= '0;
		end else if (stable_count == debounce_count_t'(debounce_cycles - 1)) begin
			stable_level <= sync_b;
			stable_count <= '0;
		end else begin
			stable_count <= stable_count + debounce_count_t'(1);
		end
	end

	// delayed copy for edge detect
	always_ff @(posedge clk) begin
		if (!reset) begin
			stable_prev <= 1'b0;
		end else begin
			stable_prev <= stable_level;
		end
	end

	// rising edge of the stable level only
	assign press_pulse = stable_level & ~stable_prev;

endmodule

// ==== frame_ram_arbiter.sv ====
module frame_ram_arbiter
	import image_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	// host write port
	input  logic   wr_valid,
	output logic   wr_ready,
	input  addr_t  wr_addr,
	input  pixel_t wr_data,
	// streamer read port
	input  logic   rd_valid,
	output logic   rd_ready,
	input  addr_t  rd_addr,
	output pixel_t rd_data,
	output logic   rd_data_valid
);

	// image memory, starts out black
	pixel_t mem [image_size] = '{default: '0};

	// set when the read side was served last
	logic last_read;
	logic wr_fire;
	logic rd_fire;

	// ------------------------------
	// grant logic
	// ------------------------------

	// a side with no competitor is granted at once
	// under contention the side not served last wins
	assign wr_ready = !rd_valid || last_read;
	assign rd_ready = !wr_valid || !last_read;

	assign wr_fire = wr_valid && wr_ready;
	assign rd_fire = rd_valid && rd_ready;

	always_ff @(posedge clk) begin
		if (!reset) begin
			last_read     <= 1'b0;
			rd_data_valid <= 1'b0;
		end else begin
			// data comes back exactly one cycle after the grant
			rd_data_valid <= rd_fire;
			if (rd_fire) begin
				last_read <= 1'b1;
			end else if (wr_fire) begin
				last_read <= 1'b0;
			end
		end
	end

	// ------------------------------
	// single port array
	// ------------------------------

	always_ff @(posedge clk) begin
		// addresses past the image are dropped
		if (wr_fire && (int'(wr_addr) < image_size)) begin
			mem[wr_addr] <= wr_data;
		end
		// registered read
		if (rd_fire) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

// ==== image_streamer.sv ====
module image_streamer
	import image_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   start,
	// read port towards the arbiter
	output logic   rd_valid,
	input  logic   rd_ready,
	output addr_t  rd_addr,
	input  pixel_t rd_data,
	input  logic   rd_data_valid,
	// pixel link towards the sender
	output logic   pix_valid,
	input  logic   pix_ready,
	output pixel_t pix_data,
	output logic   busy
);

	stream_state_t state;
	stream_state_t state_next;
	addr_t         addr;
	pixel_t        pixel_q;
	logic          last_addr;

	assign last_addr = (addr == addr_t'(image_size - 1));

	// ------------------------------
	// next state
	// ------------------------------

	always_comb begin
		state_next = state;
		case (state)
			idle: begin
				// start only counts here, a press while streaming is dropped
				if (start) begin
					state_next = fetch;
				end
			end
			fetch: begin
				if (rd_ready) begin
					state_next = wait_data;
				end
			end
			wait_data: begin
				if (rd_data_valid) begin
					state_next = offer;
				end
			end
			offer: begin
				// stall here for as long as the sender is busy
				if (pix_ready) begin
					state_next = last_addr ? idle : fetch;
				end
			end
			default: begin
				state_next = idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= idle;
			addr  <= '0;
		end else begin
			state <= state_next;
			// step the address once the pixel is handed over
			if (state == offer && pix_ready) begin
				addr <= last_addr ? '0 : addr + addr_t'(1);
			end
		end
	end

	// hold the returned pixel for the offer
	always_ff @(posedge clk) begin
		if (state == wait_data && rd_data_valid) begin
			pixel_q <= rd_data;
		end
	end

	// outputs straight from state
	assign rd_valid  = (state == fetch);
	assign rd_addr   = addr;
	assign pix_valid = (state == offer);
	assign pix_data  = pixel_q;
	assign busy      = (state != idle);

endmodule

// ==== send_pixel.sv ====
module send_pixel
	import uart_pkg::*;
	import image_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   pix_valid,
	output logic   pix_ready,
	input  pixel_t pix_data,
	output logic   uart_tx
);

	pixel_t     pixel_q;
	logic       sending;
	logic       byte_sel;
	bit_time_t  bit_timer;
	bit_index_t bit_idx;
	byte_t      cur_byte;
	logic [2:0] data_sel;
	logic       parity_bit;
	logic       tx_bit;
	logic       bit_done;
	logic       frame_done;

	// only take a new pixel when fully idle
	assign pix_ready = !sending;

	// ------------------------------
	// byte forming
	// ------------------------------

	// byte 0 upper eight bits, byte 1 low nibble padded with zeros
	assign cur_byte = byte_sel ? {pixel_q[3:0], 4'h0} : pixel_q[11:4];

	always_comb begin
		case (parity_type)
			2: parity_bit = ^cur_byte;
			1: parity_bit = ~^cur_byte;
			default: parity_bit = 1'b0;
		endcase
	end

	// ------------------------------
	// bit timing
	// ------------------------------

	assign bit_done   = (bit_timer == bit_time_t'(clks_per_bit - 1));
	assign frame_done = bit_done && (bit_idx == bit_index_t'(frame_bits - 1));

	always_ff @(posedge clk) begin
		if (!reset) begin
			sending   <= 1'b0;
			byte_sel  <= 1'b0;
			bit_timer <= '0;
			bit_idx   <= '0;
		end else if (!sending) begin
			// accept, start bit goes out next cycle
			if (pix_valid) begin
				sending   <= 1'b1;
				byte_sel  <= 1'b0;
				bit_timer <= '0;
				bit_idx   <= '0;
			end
		end else if (frame_done) begin
			bit_timer <= '0;
			bit_idx   <= '0;
			// second frame follows back to back
			if (byte_sel) begin
				sending <= 1'b0;
			end else begin
				byte_sel <= 1'b1;
			end
		end else if (bit_done) begin
			bit_timer <= '0;
			bit_idx   <= bit_idx + bit_index_t'(1);
		end else begin
			bit_timer <= bit_timer + bit_time_t'(1);
		end
	end

	// payload latch
	always_ff @(posedge clk) begin
		if (pix_valid && pix_ready) begin
			pixel_q <= pix_data;
		end
	end

	// ------------------------------
	// line mux
	// ------------------------------

	// data bit n sits at frame position n + 1, lsb first
	assign data_sel = 3'(bit_idx - bit_index_t'(1));

	always_comb begin
		if (bit_idx == '0) begin
			tx_bit = 1'b0;
		end else if (bit_idx == bit_index_t'(frame_bits - 1)) begin
			// stop
			tx_bit = 1'b1;
		end else if (bit_idx <= bit_index_t'(8)) begin
			tx_bit = cur_byte[data_sel];
		end else begin
			tx_bit = parity_bit;
		end
	end

	// line rests high
	assign uart_tx = sending ? tx_bit : 1'b1;

endmodule

// ==== pixel_link_top.sv ====
module pixel_link_top
	import image_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   start_button,
	// host write port
	input  logic   wr_valid,
	output logic   wr_ready,
	input  addr_t  wr_addr,
	input  pixel_t wr_data,
	// serial line and status
	output logic   uart_tx,
	output logic   busy
);

	logic   press_pulse;

	// streamer to arbiter
	logic   rd_valid;
	logic   rd_ready;
	addr_t  rd_addr;
	pixel_t rd_data;
	logic   rd_data_valid;

	// streamer to sender
	logic   pix_valid;
	logic   pix_ready;
	pixel_t pix_data;

	// ------------------------------
	// start button
	// ------------------------------

	button_edge button0 (
		.clk         (clk),
		.reset       (reset),
		.button      (start_button),
		.press_pulse (press_pulse)
	);

	// ------------------------------
	// frame memory
	// ------------------------------

	frame_ram_arbiter arbiter0 (
		.clk           (clk),
		.reset         (reset),
		.wr_valid      (wr_valid),
		.wr_ready      (wr_ready),
		.wr_addr       (wr_addr),
		.wr_data       (wr_data),
		.rd_valid      (rd_valid),
		.rd_ready      (rd_ready),
		.rd_addr       (rd_addr),
		.rd_data       (rd_data),
		.rd_data_valid (rd_data_valid)
	);

	// walks addresses 0 .. image_size-1
	image_streamer streamer0 (
		.clk           (clk),
		.reset         (reset),
		.start         (press_pulse),
		.rd_valid      (rd_valid),
		.rd_ready      (rd_ready),
		.rd_addr       (rd_addr),
		.rd_data       (rd_data),
		.rd_data_valid (rd_data_valid),
		.pix_valid     (pix_valid),
		.pix_ready     (pix_ready),
		.pix_data      (pix_data),
		.busy          (busy)
	);

	// two uart frames per pixel
	send_pixel sender0 (
		.clk       (clk),
		.reset     (reset),
		.pix_valid (pix_valid),
		.pix_ready (pix_ready),
		.pix_data  (pix_data),
		.uart_tx   (uart_tx)
	);

endmodule

// ==== pixel_link_checker.sv ====
module pixel_link_checker
	import image_pkg::*;
(
	input logic   clk,
	input logic   reset,
	input logic   rd_valid,
	input logic   rd_ready,
	input logic   rd_data_valid,
	input logic   pix_valid,
	input logic   pix_ready,
	input pixel_t pix_data,
	input logic   uart_tx,
	input logic   busy
);
	timeunit 1ns;
	timeprecision 1ps;

	// offered pixel held until the sender takes it
	pix_hold: assert property (@(posedge clk) disable iff (!reset)
		pix_valid && !pix_ready |=> pix_valid && $stable(pix_data))
		else $error("pix_valid dropped or pix_data changed before pix_ready");

	// read data one cycle after every granted read
	rd_return: assert property (@(posedge clk) disable iff (!reset)
		rd_valid && rd_ready |=> rd_data_valid)
		else $error("no rd_data_valid one cycle after an accepted read");

	// returned data is a single cycle pulse
	rd_pulse: assert property (@(posedge clk) disable iff (!reset)
		rd_data_valid |=> !rd_data_valid)
		else $error("rd_data_valid high for more than one cycle");

	// no frame starts while nothing is streaming
	line_idle: assert property (@(posedge clk) disable iff (!reset)
		!busy && pix_ready |=> pix_ready && uart_tx)
		else $error("uart frame started while streamer and sender were idle");

endmodule

bind pixel_link_top pixel_link_checker checker0 (
	.clk           (clk),
	.reset         (reset),
	.rd_valid      (rd_valid),
	.rd_ready      (rd_ready),
	.rd_data_valid (rd_data_valid),
	.pix_valid     (pix_valid),
	.pix_ready     (pix_ready),
	.pix_data      (pix_data),
	.uart_tx       (uart_tx),
	.busy          (busy)
);

// ==== pixel_link_tb.sv ====
module pixel_link_tb
	import uart_pkg::*;
	import image_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int write_timeout  = 50;
	localparam int frame_timeout  = 500;
	localparam int stream_timeout = 4000;
	localparam int table_len      = 8;

	logic   clk;
	logic   reset;
	logic   start_button;
	logic   wr_valid;
	logic   wr_ready;
	addr_t  wr_addr;
	pixel_t wr_data;
	logic   uart_tx;
	logic   busy;

	// expected memory contents
	pixel_t model [image_size];
	// start bits seen in the current stream
	int     frames_started;

	// ------------------------------
	// write table
	// ------------------------------

	typedef struct packed {
		addr_t  addr;
		pixel_t pixel;
	} write_entry_t;

	// corners and edge values, every other address random
	write_entry_t write_table [table_len] = '{
		'{7'd0, 12'hfff}, '{7'd1, 12'h000}, '{7'd5, 12'h800}, '{7'd42, 12'h001},
		'{7'd63, 12'ha5a}, '{7'd64, 12'h5a5}, '{7'd98, 12'h123}, '{7'd99, 12'hedc}
	};

	pixel_link_top dut0 (
		.clk          (clk),
		.reset        (reset),
		.start_button (start_button),
		.wr_valid     (wr_valid),
		.wr_ready     (wr_ready),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.uart_tx      (uart_tx),
		.busy         (busy)
	);

	always #10 clk = ~clk;

	// ------------------------------
	// helpers
	// ------------------------------

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] got);
		if (got !== expected) begin
			$display("Error %s expected %h got %h", name, expected, got);
			$display("ERRORS FOUND");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timed out waiting for %s", what);
		$display("ERRORS FOUND");
		$fatal(1, "timeout");
	endtask

	// hold the request until ready, seen at the falling edge
	task automatic write_pixel(input addr_t a, input pixel_t d);
		int n;
		wr_addr  = a;
		wr_data  = d;
		wr_valid = 1'b1;
		n = 0;
		while (!wr_ready) begin
			@(negedge clk);
			n++;
			if (n > write_timeout) report_timeout("wr_ready on the host port");
		end
		// write lands on the rising edge in between
		@(negedge clk);
		wr_valid = 1'b0;
		model[a] = d;
	endtask

	task automatic press_button(input int cycles);
		start_button = 1'b1;
		repeat (cycles) @(negedge clk);
		start_button = 1'b0;
	endtask

	task automatic wait_busy(input logic level);
		int n;
		n = 0;
		while (busy !== level) begin
			@(negedge clk);
			n++;
			if (n > stream_timeout) report_timeout("busy to change");
		end
	endtask

	task automatic wait_frames(input int count);
		int n;
		n = 0;
		while (frames_started < count) begin
			@(negedge clk);
			n++;
			if (n > stream_timeout) report_timeout("uart frames to start");
		end
	endtask

	// line must stay quiet, catches extra frames and restarts
	task automatic check_idle(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			check_value("uart_tx", 32'(1), 32'(uart_tx));
			check_value("busy", 32'(0), 32'(busy));
		end
	endtask

	// uart decoder, samples each bit near its middle
	task automatic receive_frame(output byte_t data, output logic parity, output logic stop);
		int n;
		n = 0;
		while (uart_tx !== 1'b0) begin
			@(negedge clk);
			n++;
			if (n > frame_timeout) report_timeout("a uart start bit");
		end
		frames_started++;
		repeat (clks_per_bit / 2) @(negedge clk);
		check_value("uart_tx start bit", 32'(0), 32'(uart_tx));
		for (int i = 0; i < 8; i++) begin
			repeat (clks_per_bit) @(negedge clk);
			data[i] = uart_tx;
		end
		repeat (clks_per_bit) @(negedge clk);
		parity = uart_tx;
		repeat (clks_per_bit) @(negedge clk);
		stop = uart_tx;
	endtask

	// two frames per pixel, compared against the model
	task automatic receive_image();
		byte_t b;
		logic  p;
		logic  s;
		for (int a = 0; a < image_size; a++) begin
			receive_frame(b, p, s);
			check_value("uart_tx parity", 32'(0), 32'(^{b, p}));
			check_value("uart_tx stop bit", 32'(1), 32'(s));
			check_value($sformatf("uart_tx high byte of pixel %0d", a),
				32'(model[a][11:4]), 32'(b));
			receive_frame(b, p, s);
			check_value("uart_tx parity", 32'(0), 32'(^{b, p}));
			check_value("uart_tx stop bit", 32'(1), 32'(s));
			check_value($sformatf("uart_tx low byte of pixel %0d", a),
				32'({model[a][3:0], 4'h0}), 32'(b));
		end
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------

	initial begin
		pixel_t new_pixel;
		clk            = 1'b0;
		reset          = 1'b0;
		start_button   = 1'b0;
		wr_valid       = 1'b0;
		wr_addr        = '0;
		wr_data        = '0;
		frames_started = 0;
		void'($urandom(70933));
		repeat (16) @(negedge clk);
		reset = 1'b1;
		@(negedge clk);

		// idle levels out of reset
		check_value("uart_tx", 32'(1), 32'(uart_tx));
		check_value("busy", 32'(0), 32'(busy));
		check_value("wr_ready", 32'(1), 32'(wr_ready));

		// glitch shorter than the debounce window
		press_button(debounce_cycles - 1);
		check_idle(50);

		// load every address, table entries override the random fill
		for (int a = 0; a < image_size; a++) begin
			new_pixel = pixel_t'($urandom);
			for (int t = 0; t < table_len; t++) begin
				if (int'(write_table[t].addr) == a) new_pixel = write_table[t].pixel;
			end
			write_pixel(addr_t'(a), new_pixel);
		end

		// first stream, host write and second press land during pixel 5
		press_button(debounce_cycles + 1);
		wait_busy(1'b1);
		fork
			receive_image();
			begin
				wait_frames(11);
				new_pixel = ~model[0];
				write_pixel(addr_t'(0), new_pixel);
				press_button(debounce_cycles + 1);
			end
		join
		wait_busy(1'b0);
		check_idle(3 * frame_bits * clks_per_bit);

		// second stream picks up the new pixel 0
		frames_started = 0;
		press_button(debounce_cycles + 1);
		wait_busy(1'b1);
		receive_image();
		wait_busy(1'b0);
		check_idle(3 * frame_bits * clks_per_bit);

		$display("NO ERRORS");
		$finish;
	end

endmodule

// ==== files.f ====
uart_pkg.sv
image_pkg.sv
button_edge.sv
frame_ram_arbiter.sv
image_streamer.sv
send_pixel.sv
pixel_link_top.sv
pixel_link_checker.sv
pixel_link_tb.sv

// ==== Makefile ====
# Verilator build and run of the pixel link testbench

SIM := obj_dir/pixel_link_sim

.PHONY: all lint clean

all: $(SIM)
	./$(SIM)

$(SIM): files.f *.sv
	verilator --binary --timing --assert -f files.f --top-module pixel_link_tb \
		-o pixel_link_sim

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module pixel_link_tb

clean:
	rm -rf obj_dir
